/* owt_rx_stim.txt */
# len cmd data crc_mask fault(0 none,1 violation,2 stall) mode add_sel sub_sel
# ready_dly(ff holds ready low over the next frame) exp_err exp_com_err, all hex
4 a5 1234 00 0 0 0 1 2 0 1
6 3c beef 00 0 0 0 3 0 0 1
9 81 0f0f 00 0 0 3 3 4 0 0
6 42 5555 10 0 0 1 0 1 1 1
6 13 a0c3 00 1 0 1 0 2 1 1
4 7e 0001 00 2 0 3 0 1 1 1
6 c0 00ff 00 0 1 0 3 0 0 0
6 99 6666 00 0 1 0 3 ff 0 1
5 55 aaaa 00 0 1 0 0 3 0 1
9 e7 8001 ff 0 0 2 0 2 1 1
8 01 fffe 00 0 0 2 1 0 0 0

/* sources.f */
owt_pkg.sv
owt_symbol_timer.sv
owt_manchester_dec.sv
owt_crc8.sv
owt_err_monitor.sv
owt_frame_ctrl.sv
owt_rx_top.sv
tb_owt_rx.sv

/* Bender.yml */
package:
  name: owt_rx

sources:
  - owt_pkg.sv
  - owt_symbol_timer.sv
  - owt_manchester_dec.sv
  - owt_crc8.sv
  - owt_err_monitor.sv
  - owt_frame_ctrl.sv
  - owt_rx_top.sv
  - target: test
    files:
      - tb_owt_rx.sv

/* tb_owt_rx.sv */
module tb_owt_rx;
    timeunit 1ns;
    timeprecision 1ps;
    import owt_pkg::*;

    localparam int TMO_CYC    = 4000;
    localparam int FRAME_SYMS = 100;
    localparam int MAX_TESTS  = 32;

    logic                  i_clk = 1'b0;
    logic                  i_rst_n;
    logic                  i_owt_rx;
    logic                  i_err_mode;
    logic [1:0]            i_err_add_sel;
    logic [1:0]            i_err_sub_sel;
    logic                  o_frame_valid;
    logic                  i_frame_ready;
    logic [OWT_CMD_W-1:0]  o_frame_cmd;
    logic [OWT_DATA_W-1:0] o_frame_data;
    logic                  o_frame_err;
    logic                  o_frame_drop;
    logic                  o_com_err;

    // one entry per stim line
    int t_len[MAX_TESTS];
    int t_cmd[MAX_TESTS];
    int t_data[MAX_TESTS];
    int t_mask[MAX_TESTS];
    int t_fault[MAX_TESTS];
    int t_mode[MAX_TESTS];
    int t_add[MAX_TESTS];
    int t_sub[MAX_TESTS];
    int t_rdy[MAX_TESTS];
    int t_err[MAX_TESTS];
    int t_com[MAX_TESTS];
    int n_tests  = 0;
    int err_cnt  = 0;
    int drop_cnt = 0;
    int wd_cycles = 0;
    logic line_q[$];

    owt_rx_top #(
        .TMO_CYC (TMO_CYC)
    ) dut0 (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_owt_rx      (i_owt_rx),
        .i_err_mode    (i_err_mode),
        .i_err_add_sel (i_err_add_sel),
        .i_err_sub_sel (i_err_sub_sel),
        .o_frame_valid (o_frame_valid),
        .i_frame_ready (i_frame_ready),
        .o_frame_cmd   (o_frame_cmd),
        .o_frame_data  (o_frame_data),
        .o_frame_err   (o_frame_err),
        .o_frame_drop  (o_frame_drop),
        .o_com_err     (o_com_err)
    );

    always #20 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        if (i_rst_n && o_frame_drop) begin
            drop_cnt <= drop_cnt + 1;
        end
    end

    // ========================================
    // compare tasks
    // ========================================
    task automatic check_cmd(input logic [OWT_CMD_W-1:0] got, input logic [OWT_CMD_W-1:0] exp);
        if (got !== exp) begin
            $display("Fail o_frame_cmd got %h expected %h", got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_data(input logic [OWT_DATA_W-1:0] got,
                              input logic [OWT_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("Fail o_frame_data got %h expected %h", got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_err(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail o_frame_err got %h expected %h", got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    // crc-8 poly 0x07, init zero, msb first
    function automatic logic [OWT_CRC_W-1:0] crc8_calc(input logic [23:0] msg);
        logic [OWT_CRC_W-1:0] r;
        logic                 fb;
        r = '0;
        for (int i = 23; i >= 0; i--) begin
            fb = r[OWT_CRC_W-1] ^ msg[i];
            r  = {r[OWT_CRC_W-2:0], 1'b0};
            if (fb) begin
                r = r ^ OWT_CRC_POLY;
            end
        end
        return r;
    endfunction

    // ========================================
    // line waveform, one entry per symbol
    // ========================================
    task automatic build_frame(input int k);
        logic [31:0] bits;
        logic        v;
        logic        cut;
        bits = {t_cmd[k][7:0], t_data[k][15:0], 8'h00};
        bits[7:0] = crc8_calc(bits[31:8]) ^ t_mask[k][7:0];
        cut = 1'b0;
        line_q.delete();
        repeat (8) line_q.push_back(1'b0);
        for (int i = 0; i < OWT_SYNC_PULSES; i++) begin
            line_q.push_back(1'b1);
            line_q.push_back(1'b0);
        end
        line_q.push_back(1'b1);
        if (t_fault[k] != 2) begin
            // rest of the tail
            line_q.push_back(1'b1);
            line_q.push_back(1'b0);
            line_q.push_back(1'b0);
            for (int i = 31; i >= 0; i--) begin
                v = bits[i];
                if (!cut && t_fault[k] == 1 && i == 19) begin
                    // stretched first half of a data bit
                    repeat (3) line_q.push_back(v);
                    line_q.push_back(~v);
                    cut = 1'b1;
                end else if (!cut) begin
                    line_q.push_back(v);
                    line_q.push_back(~v);
                end
            end
            if (!cut) begin
                line_q.push_back(1'b1);
                line_q.push_back(1'b1);
            end
            repeat (5) line_q.push_back(1'b0);
        end
    endtask

    task automatic drive_line(input int len);
        int   i;
        int   n;
        int   cyc;
        logic lvl;
        i = 0;
        while (i < line_q.size()) begin
            lvl = line_q[i];
            n   = 0;
            while (i < line_q.size() && line_q[i] == lvl) begin
                n++;
                i++;
            end
            cyc = n * len;
            // jitter per edge-to-edge run
            if (len >= 8) begin
                cyc = cyc + int'($urandom % 3) - 1;
            end
            i_owt_rx = lvl;
            repeat (cyc) @(negedge i_clk);
        end
    endtask

    task automatic wait_valid(input int limit, output logic seen);
        int n;
        n = 0;
        while (!o_frame_valid && n < limit) begin
            @(negedge i_clk);
            n++;
        end
        seen = o_frame_valid;
        if (!seen) begin
            $display("no result came out within %0d cycles", limit);
            err_cnt++;
        end
    endtask

    task automatic release_ready(input int dly);
        repeat (dly) @(negedge i_clk);
        i_frame_ready = 1'b1;
        @(negedge i_clk);
        i_frame_ready = 1'b0;
        check_flag("o_frame_valid", o_frame_valid, 1'b0);
    endtask

    task automatic read_stim();
        int    fd;
        int    r;
        string line_s;
        fd = $fopen("owt_rx_stim.txt", "r");
        if (fd == 0) begin
            $display("stim file owt_rx_stim.txt could not be opened");
            err_cnt++;
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                r = $fgets(line_s, fd);
                if (r > 1 && line_s.getc(0) != "#") begin
                    r = $sscanf(line_s, "%h %h %h %h %h %h %h %h %h %h %h",
                                t_len[n_tests], t_cmd[n_tests], t_data[n_tests],
                                t_mask[n_tests], t_fault[n_tests], t_mode[n_tests],
                                t_add[n_tests], t_sub[n_tests], t_rdy[n_tests],
                                t_err[n_tests], t_com[n_tests]);
                    if (r == 11) begin
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        int          errs_before;
        int          drops_before;
        int          total;
        logic        seen;
        logic        held;
        logic [31:0] held_cmd;
        logic [31:0] held_data;
        logic        held_err;

        i_rst_n       = 1'b0;
        i_owt_rx      = 1'b0;
        i_err_mode    = 1'b0;
        i_err_add_sel = 2'd0;
        i_err_sub_sel = 2'd0;
        i_frame_ready = 1'b0;
        held          = 1'b0;
        held_cmd      = '0;
        held_data     = '0;
        held_err      = 1'b0;
        void'($urandom(32'hd891));

        read_stim();
        total = 0;
        for (int k = 0; k < n_tests; k++) begin
            total += FRAME_SYMS * (t_len[k] + 1) + t_rdy[k];
            if (t_fault[k] == 2) begin
                total += TMO_CYC;
            end
        end
        wd_cycles = 2 * total + 200;

        repeat (16) @(negedge i_clk);
        i_rst_n = 1'b1;
        @(negedge i_clk);
        check_flag("o_com_err", o_com_err, 1'b1);

        for (int k = 0; k < n_tests; k++) begin
            errs_before   = err_cnt;
            i_err_mode    = t_mode[k][0];
            i_err_add_sel = t_add[k][1:0];
            i_err_sub_sel = t_sub[k][1:0];
            drops_before  = drop_cnt;
            build_frame(k);
            drive_line(t_len[k]);
            if (held) begin
                // earlier result still on the port, this frame lost
                check_flag("o_frame_valid", o_frame_valid, 1'b1);
                check_cmd(o_frame_cmd, held_cmd[7:0]);
                check_data(o_frame_data, held_data[15:0]);
                check_err(o_frame_err, held_err);
                check_flag("o_frame_drop", (drop_cnt - drops_before) == 1, 1'b1);
                held = 1'b0;
                repeat (2) @(negedge i_clk);
                check_flag("o_com_err", o_com_err, t_com[k][0]);
                release_ready(t_rdy[k]);
            end else begin
                wait_valid(TMO_CYC + FRAME_SYMS * (t_len[k] + 1), seen);
                if (t_fault[k] == 2) begin
                    i_owt_rx = 1'b0;
                end
                if (seen) begin
                    check_err(o_frame_err, t_err[k][0]);
                    if (t_fault[k] == 0) begin
                        check_cmd(o_frame_cmd, t_cmd[k][7:0]);
                        check_data(o_frame_data, t_data[k][15:0]);
                    end
                    check_flag("o_frame_drop", (drop_cnt - drops_before) != 0, 1'b0);
                    repeat (2) @(negedge i_clk);
                    check_flag("o_com_err", o_com_err, t_com[k][0]);
                    if (t_rdy[k] == 'hff) begin
                        held      = 1'b1;
                        held_cmd  = t_cmd[k];
                        held_data = t_data[k];
                        held_err  = t_err[k][0];
                    end else begin
                        release_ready(t_rdy[k]);
                    end
                end
            end
            if (err_cnt == errs_before) begin
                $display("test %0d len %0d cmd %h data %h ok", k, t_len[k], t_cmd[k][7:0],
                         t_data[k][15:0]);
            end else begin
                $display("test %0d len %0d cmd %h data %h FAILED", k, t_len[k],
                         t_cmd[k][7:0], t_data[k][15:0]);
            end
        end

        $display("tests %0d, errors %0d", n_tests, err_cnt);
        if (err_cnt == 0 && n_tests > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // watchdog sized from the stim once it is read
    initial begin
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge i_clk);
        $display("watchdog expired after %0d cycles, run stopped", wd_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* owt_rx_top.sv */
module owt_rx_top #(
    parameter int TMO_CYC = 4000
) (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_owt_rx,
    input  logic                           i_err_mode,
    input  logic [1:0]                     i_err_add_sel,
    input  logic [1:0]                     i_err_sub_sel,
    output logic                           o_frame_valid,
    input  logic                           i_frame_ready,
    output logic [owt_pkg::OWT_CMD_W-1:0]  o_frame_cmd,
    output logic [owt_pkg::OWT_DATA_W-1:0] o_frame_data,
    output logic                           o_frame_err,
    output logic                           o_frame_drop,
    output logic                           o_com_err
);
    import owt_pkg::*;

    logic                 measure_en;
    logic                 avg_en;
    logic                 rise;
    logic                 sym_vld;
    owt_sym_e             sym_class;
    logic                 sym_rise;
    logic                 decode_en;
    logic                 field_start;
    logic                 bit_vld;
    logic                 bit_val;
    logic                 violation;
    logic                 crc_bit_vld;
    logic                 crc_restart;
    logic [OWT_CRC_W-1:0] crc;
    logic                 done;
    logic                 done_err;

    owt_symbol_timer u_symbol_timer (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_owt_rx     (i_owt_rx),
        .i_measure_en (measure_en),
        .i_avg_en     (avg_en),
        .o_rise       (rise),
        .o_sym_vld    (sym_vld),
        .o_sym_class  (sym_class),
        .o_sym_rise   (sym_rise)
    );

    owt_manchester_dec u_manchester_dec (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_sym_vld     (sym_vld),
        .i_sym_class   (sym_class),
        .i_sym_rise    (sym_rise),
        .i_decode_en   (decode_en),
        .i_field_start (field_start),
        .o_bit_vld     (bit_vld),
        .o_bit         (bit_val),
        .o_violation   (violation)
    );

    owt_frame_ctrl #(
        .TMO_CYC (TMO_CYC)
    ) u_frame_ctrl (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_rise         (rise),
        .i_sym_vld      (sym_vld),
        .i_sym_rise     (sym_rise),
        .i_bit_vld      (bit_vld),
        .i_bit          (bit_val),
        .i_violation    (violation),
        .i_crc          (crc),
        .o_measure_en   (measure_en),
        .o_avg_en       (avg_en),
        .o_decode_en    (decode_en),
        .o_field_start  (field_start),
        .o_crc_bit_vld  (crc_bit_vld),
        .o_crc_restart  (crc_restart),
        .o_done         (done),
        .o_done_err     (done_err),
        .o_frame_valid  (o_frame_valid),
        .i_frame_ready  (i_frame_ready),
        .o_frame_cmd    (o_frame_cmd),
        .o_frame_data   (o_frame_data),
        .o_frame_err    (o_frame_err),
        .o_frame_drop   (o_frame_drop)
    );

    owt_crc8 u_crc8 (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_bit_vld (crc_bit_vld),
        .i_bit     (bit_val),
        .i_restart (crc_restart),
        .o_crc     (crc)
    );

    owt_err_monitor u_err_monitor (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_done        (done),
        .i_done_err    (done_err),
        .i_err_mode    (i_err_mode),
        .i_err_add_sel (i_err_add_sel),
        .i_err_sub_sel (i_err_sub_sel),
        .o_com_err     (o_com_err)
    );

endmodule

/* owt_frame_ctrl.sv */
module owt_frame_ctrl #(
    parameter int TMO_CYC = 4000
) (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_rise,
    input  logic                           i_sym_vld,
    input  logic                           i_sym_rise,
    input  logic                           i_bit_vld,
    input  logic                           i_bit,
    input  logic                           i_violation,
    input  logic [owt_pkg::OWT_CRC_W-1:0]  i_crc,
    output logic                           o_measure_en,
    output logic                           o_avg_en,
    output logic                           o_decode_en,
    output logic                           o_field_start,
    output logic                           o_crc_bit_vld,
    output logic                           o_crc_restart,
    output logic                           o_done,
    output logic                           o_done_err,
    output logic                           o_frame_valid,
    input  logic                           i_frame_ready,
    output logic [owt_pkg::OWT_CMD_W-1:0]  o_frame_cmd,
    output logic [owt_pkg::OWT_DATA_W-1:0] o_frame_data,
    output logic                           o_frame_err,
    output logic                           o_frame_drop
);
    import owt_pkg::*;

    localparam int TMO_W = $clog2(TMO_CYC + 1);

    owt_state_e               state;
    owt_state_e               state_nxt;
    logic [OWT_BIT_CNT_W-1:0] bit_cnt;
    logic [OWT_CMD_W-1:0]     cmd_sr;
    logic [OWT_DATA_W-1:0]    data_sr;
    logic [OWT_CRC_W-1:0]     crc_sr;
    logic [TMO_W-1:0]         tmo_cnt;
    logic                     timeout;
    logic                     sym_fall;
    logic                     field_last;
    logic                     frame_end;
    logic                     accept;

    // ========================================
    // frame sequencing
    // ========================================
    // line shape: one rise leaves idle, six more rises end the head
    // (the last one opens the tail: two high, two low), then
    // manchester cmd, data, crc and a closing falling edge

    assign sym_fall = i_sym_vld & ~i_sym_rise;

    always_comb begin
        case (state)
            OWT_CMD:  field_last = (bit_cnt == OWT_BIT_CNT_W'(OWT_CMD_W - 1));
            OWT_DATA: field_last = (bit_cnt == OWT_BIT_CNT_W'(OWT_DATA_W - 1));
            default:  field_last = (bit_cnt == OWT_BIT_CNT_W'(OWT_CRC_W - 1));
        endcase
    end

    always_comb begin
        state_nxt = state;
        frame_end = 1'b0;
        case (state)
            OWT_IDLE: begin
                if (i_rise) begin
                    state_nxt = OWT_SYNC_HEAD;
                end
            end
            OWT_SYNC_HEAD: begin
                if (i_rise && (bit_cnt == OWT_BIT_CNT_W'(OWT_SYNC_PULSES - 1))) begin
                    state_nxt = OWT_SYNC_TAIL;
                end
            end
            OWT_SYNC_TAIL: begin
                if (sym_fall) begin
                    state_nxt = OWT_CMD;
                end
            end
            OWT_CMD: begin
                if (i_bit_vld && field_last) begin
                    state_nxt = OWT_DATA;
                end
            end
            OWT_DATA: begin
                if (i_bit_vld && field_last) begin
                    state_nxt = OWT_CRC;
                end
            end
            OWT_CRC: begin
                if (i_bit_vld && field_last) begin
                    state_nxt = OWT_END_TAIL;
                end
            end
            OWT_END_TAIL: begin
                if (sym_fall) begin
                    state_nxt = OWT_IDLE;
                    frame_end = 1'b1;
                end
            end
            default: begin
                state_nxt = OWT_IDLE;
            end
        endcase
        // abort paths
        if (timeout || i_violation) begin
            state_nxt = OWT_IDLE;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= OWT_IDLE;
            bit_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state_nxt != state) begin
                bit_cnt <= '0;
            end else if (((state == OWT_SYNC_HEAD) && i_rise) || i_bit_vld) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // field shift registers, msb first
    always_ff @(posedge i_clk) begin
        if (i_bit_vld) begin
            case (state)
                OWT_CMD:  cmd_sr  <= {cmd_sr[OWT_CMD_W-2:0], i_bit};
                OWT_DATA: data_sr <= {data_sr[OWT_DATA_W-2:0], i_bit};
                OWT_CRC:  crc_sr  <= {crc_sr[OWT_CRC_W-2:0], i_bit};
                default: begin
                end
            endcase
        end
    end

    // timeout from frame start
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tmo_cnt <= '0;
        end else if (state == OWT_IDLE) begin
            tmo_cnt <= '0;
        end else begin
            tmo_cnt <= tmo_cnt + 1'b1;
        end
    end

    assign timeout = (state != OWT_IDLE) && (tmo_cnt == TMO_W'(TMO_CYC - 1));

    assign o_measure_en  = (state != OWT_IDLE);
    assign o_avg_en      = (state == OWT_SYNC_HEAD);
    assign o_decode_en   = (state == OWT_CMD) || (state == OWT_DATA) || (state == OWT_CRC);
    assign o_field_start = (state == OWT_CMD) && (bit_cnt == '0);
    assign o_crc_bit_vld = i_bit_vld && ((state == OWT_CMD) || (state == OWT_DATA));
    assign o_crc_restart = o_field_start;

    assign o_done     = frame_end | timeout | i_violation;
    assign o_done_err = timeout | i_violation | (crc_sr != i_crc);

    // ========================================
    // one-entry result holding register
    // ========================================
    assign accept = o_done && (!o_frame_valid || i_frame_ready);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_frame_valid <= 1'b0;
            o_frame_drop  <= 1'b0;
        end else begin
            o_frame_drop <= o_done && o_frame_valid && !i_frame_ready;
            if (accept) begin
                o_frame_valid <= 1'b1;
            end else if (i_frame_ready) begin
                o_frame_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_frame_cmd  <= cmd_sr;
            o_frame_data <= data_sr;
            o_frame_err  <= o_done_err;
        end
    end

    a_valid_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(o_frame_valid) |-> $past(i_frame_ready));

endmodule

/* owt_err_monitor.sv */
module owt_err_monitor (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_done,
    input  logic       i_done_err,
    input  logic       i_err_mode,
    input  logic [1:0] i_err_add_sel,
    input  logic [1:0] i_err_sub_sel,
    output logic       o_com_err
);
    import owt_pkg::*;

    logic [OWT_ERR_SCORE_W-1:0] score;
    logic [OWT_ERR_SCORE_W-1:0] add_step;
    logic [OWT_ERR_SCORE_W-1:0] sub_step;
    logic [OWT_ERR_SCORE_W:0]   score_sum;

    assign add_step  = OWT_ERR_ADD_STEP[i_err_add_sel];
    assign sub_step  = OWT_ERR_SUB_STEP[i_err_sub_sel];
    assign score_sum = score + add_step;

    // saturating score, starts at the ceiling
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            score <= OWT_ERR_SCORE_MAX;
        end else if (i_done && i_done_err) begin
            if (score_sum > OWT_ERR_SCORE_MAX) begin
                score <= OWT_ERR_SCORE_MAX;
            end else begin
                score <= score_sum[OWT_ERR_SCORE_W-1:0];
            end
        end else if (i_done) begin
            score <= (sub_step >= score) ? '0 : (score - sub_step);
        end
    end

    // mode 1 flags a clean history, mode 0 a score at or above one add step
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_com_err <= 1'b1;
        end else if (i_err_mode) begin
            o_com_err <= (score == '0);
        end else begin
            o_com_err <= (score >= add_step);
        end
    end

endmodule

/* owt_crc8.sv */
module owt_crc8 (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_bit_vld,
    input  logic                          i_bit,
    input  logic                          i_restart,
    output logic [owt_pkg::OWT_CRC_W-1:0] o_crc
);
    import owt_pkg::*;

    logic [OWT_CRC_W-1:0] crc_base;
    logic                 feedback;

    // restart absorbs the first bit into a cleared remainder
    assign crc_base = i_restart ? '0 : o_crc;
    assign feedback = crc_base[OWT_CRC_W-1] ^ i_bit;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_crc <= '0;
        end else if (i_bit_vld) begin
            o_crc <= {crc_base[OWT_CRC_W-2:0], 1'b0} ^ (feedback ? OWT_CRC_POLY : '0);
        end
    end

endmodule

/* owt_manchester_dec.sv */
module owt_manchester_dec (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_sym_vld,
    input  owt_pkg::owt_sym_e i_sym_class,
    input  logic              i_sym_rise,
    input  logic              i_decode_en,
    input  logic              i_field_start,
    output logic              o_bit_vld,
    output logic              o_bit,
    output logic              o_violation
);
    import owt_pkg::*;

    logic mid_cell;
    logic mid_cell_nxt;

    // falling edge at mid-cell is a one
    assign o_bit = ~i_sym_rise;

    always_comb begin
        mid_cell_nxt = mid_cell;
        o_bit_vld    = 1'b0;
        o_violation  = 1'b0;
        if (i_sym_vld && i_decode_en) begin
            case (i_sym_class)
                OWT_SYM_ONE: begin
                    mid_cell_nxt = ~mid_cell;
                    o_bit_vld    = ~mid_cell;
                end
                OWT_SYM_TWO: begin
                    // after the tail a rising two lands on the first boundary
                    if (mid_cell) begin
                        o_bit_vld = 1'b1;
                    end else if (!(i_field_start && i_sym_rise)) begin
                        o_violation = 1'b1;
                    end
                end
                OWT_SYM_THREE: begin
                    // only a leading zero may follow the two low tail symbols
                    if (i_field_start && i_sym_rise && !mid_cell) begin
                        mid_cell_nxt = 1'b1;
                        o_bit_vld    = 1'b1;
                    end else begin
                        o_violation = 1'b1;
                    end
                end
                default: begin
                    o_violation = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mid_cell <= 1'b0;
        end else if (!i_decode_en) begin
            mid_cell <= 1'b0;
        end else begin
            mid_cell <= mid_cell_nxt;
        end
    end

    a_bit_or_violation: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_bit_vld && o_violation));

endmodule

/* owt_symbol_timer.sv */
module owt_symbol_timer (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_owt_rx,
    input  logic              i_measure_en,
    input  logic              i_avg_en,
    output logic              o_rise,
    output logic              o_sym_vld,
    output owt_pkg::owt_sym_e o_sym_class,
    output logic              o_sym_rise
);
    import owt_pkg::*;

    logic                     rx_meta;
    logic                     rx_sync;
    logic                     rx_dly;
    logic                     rx_edge;
    logic                     measuring;
    logic                     closes;
    logic [OWT_SYM_CNT_W-1:0] sym_cnt;
    logic [OWT_SYM_CNT_W-1:0] sym_avg;
    logic [OWT_SYM_CNT_W:0]   avg_sum;
    logic [3:0]               avg_num;
    logic [OWT_SYM_CNT_W+1:0] one_up_th;
    logic [OWT_SYM_CNT_W+1:0] two_up_th;
    owt_sym_e                 sym_class;

    // two synchronizing flops and a third stage for edge detect
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_meta <= 1'b0;
            rx_sync <= 1'b0;
            rx_dly  <= 1'b0;
        end else begin
            rx_meta <= i_owt_rx;
            rx_sync <= rx_meta;
            rx_dly  <= rx_sync;
        end
    end

    assign o_rise  = rx_sync & ~rx_dly;
    assign rx_edge = rx_sync ^ rx_dly;
    assign closes  = measuring & rx_edge;

    // cycles since the previous edge from the first rise on
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            measuring <= 1'b0;
            sym_cnt   <= '0;
        end else if (!i_measure_en) begin
            measuring <= 1'b0;
            sym_cnt   <= '0;
        end else if (closes || o_rise) begin
            measuring <= 1'b1;
            sym_cnt   <= OWT_SYM_CNT_W'(1);
        end else if (measuring && (sym_cnt != '1)) begin
            sym_cnt <= sym_cnt + 1'b1;
        end
    end

    // first interval loads and later ones halve into the average
    assign avg_sum = sym_cnt + sym_avg;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sym_avg <= '0;
            avg_num <= '0;
        end else if (!i_measure_en) begin
            avg_num <= '0;
        end else if (i_avg_en && closes && (avg_num < OWT_AVG_PULSES)) begin
            sym_avg <= (avg_num == '0) ? sym_cnt : avg_sum[OWT_SYM_CNT_W:1];
            avg_num <= avg_num + 1'b1;
        end
    end

    // thresholds at 1.5 and 2.5 symbols
    assign one_up_th = sym_avg + (sym_avg >> 1);
    assign two_up_th = {sym_avg, 1'b0} + (sym_avg >> 1);

    always_comb begin
        if (sym_cnt <= one_up_th) begin
            sym_class = OWT_SYM_ONE;
        end else if (sym_cnt <= two_up_th) begin
            sym_class = OWT_SYM_TWO;
        end else begin
            sym_class = OWT_SYM_THREE;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_sym_vld   <= 1'b0;
            o_sym_class <= OWT_SYM_NONE;
            o_sym_rise  <= 1'b0;
        end else begin
            o_sym_vld   <= closes;
            o_sym_class <= closes ? sym_class : OWT_SYM_NONE;
            o_sym_rise  <= o_rise;
        end
    end

    // a measured interval never runs into the counter ceiling
    a_cnt_no_wrap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        closes |-> (sym_cnt != '1));

endmodule

/* owt_pkg.sv */
package owt_pkg;

    // ========================================
    // frame fields
    // ========================================

    // command msb is the write flag, low 7 bits the register address
    localparam int OWT_CMD_W  = 8;
    localparam int OWT_DATA_W = 16;
    localparam int OWT_CRC_W  = 8;

    // sync head shape and averaging window
    localparam int OWT_SYNC_PULSES = 6;
    localparam int OWT_AVG_PULSES  = 8;

    // counter widths
    localparam int OWT_SYM_CNT_W = 8;
    localparam int OWT_BIT_CNT_W = 5;

    // crc-8, init 0x00, msb first over cmd then data
    localparam logic [OWT_CRC_W-1:0] OWT_CRC_POLY = 8'h07;

    // interval classes
    typedef enum logic [1:0] {
        OWT_SYM_NONE,
        OWT_SYM_ONE,
        OWT_SYM_TWO,
        OWT_SYM_THREE
    } owt_sym_e;

    typedef enum logic [2:0] {
        OWT_IDLE,
        OWT_SYNC_HEAD,
        OWT_SYNC_TAIL,
        OWT_CMD,
        OWT_DATA,
        OWT_CRC,
        OWT_END_TAIL
    } owt_state_e;

    // ========================================
    // communication error score
    // ========================================
    localparam int OWT_ERR_SCORE_W = 4;
    localparam logic [OWT_ERR_SCORE_W-1:0] OWT_ERR_SCORE_MAX = 4'd15;

    // index 0 holds the smallest step
    localparam logic [3:0][OWT_ERR_SCORE_W-1:0] OWT_ERR_ADD_STEP = {4'd8, 4'd4, 4'd2, 4'd1};
    localparam logic [3:0][OWT_ERR_SCORE_W-1:0] OWT_ERR_SUB_STEP = {4'd8, 4'd4, 4'd2, 4'd1};

endpackage
